// File: verilog/sysctl_pkg.sv
// Address views assume a RAM of at most 16384 words and one system-register page at region F
`default_nettype none

package sysctl_pkg;

	// RAM view of a bus address
	typedef struct packed {
		logic [15:0] upper;
		logic [13:0] word;
		logic [1:0]  lane;
	} ram_addr_t;

	// System-register view of a bus address
	typedef struct packed {
		logic [3:0]  region;
		logic [11:0] unused;
		logic [15:0] offset;
	} reg_addr_t;

	typedef union packed {
		ram_addr_t ram;
		reg_addr_t regs;
	} sys_addr_u;

	// All strobes low means a read
	typedef struct packed {
		sys_addr_u   addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} mem_req_t;

	typedef struct packed {
		logic txbusy;
		logic dr;
	} uart_status_t;

	localparam logic [3:0] SYSREG_REGION = 4'hf;

	localparam logic [15:0] REG_UART_DATA   = 16'h0000;
	localparam logic [15:0] REG_UART_STATUS = 16'h0004;
	localparam logic [15:0] REG_LED         = 16'h1000;
	localparam logic [15:0] REG_SECONDS     = 16'h1100;

endpackage

`default_nettype wire

// File: verilog/mem_router.sv
// Master must hold valid and the request until ready and drop valid before the next request
`timescale 1ns/1ps
`default_nettype none

module mem_router import sysctl_pkg::*; #(
	parameter int BRAM_WORDS = 1536
) (
	input  wire logic        clk,
	input  wire logic        resetn,
	input  wire logic        mem_valid_i,
	input  wire mem_req_t    mem_req_i,
	output logic             mem_ready_o,
	output logic [31:0]      mem_rdata_o,
	output logic             ram_sel_o,
	output logic             reg_sel_o,
	output mem_req_t         req_o,
	input  wire logic        ram_ready_i,
	input  wire logic [31:0] ram_rdata_i,
	input  wire logic        reg_ready_i,
	input  wire logic [31:0] reg_rdata_i
);

	localparam logic [31:0] RAM_BYTES = 32'(BRAM_WORDS * 4);

	logic hit_ram;
	logic hit_reg;
	logic active;
	logic done;
	logic unmap_ready;

	assign hit_ram = mem_req_i.addr < RAM_BYTES;
	assign hit_reg = !hit_ram && (mem_req_i.addr.regs.region == SYSREG_REGION);

	// Request open and not yet answered
	assign active = resetn && mem_valid_i && !done && !mem_ready_o;

	assign ram_sel_o = active && hit_ram;
	assign reg_sel_o = active && hit_reg;
	assign req_o     = mem_req_i;

	// done stays set from the answer until valid drops, and through reset
	always_ff @(posedge clk) begin
		if (!resetn) begin
			done        <= 1'b1;
			unmap_ready <= 1'b0;
		end else begin
			unmap_ready <= active && !hit_ram && !hit_reg;
			if (!mem_valid_i)
				done <= 1'b0;
			else if (mem_ready_o)
				done <= 1'b1;
		end
	end

	// At most one target answers in a cycle
	assign mem_ready_o = ram_ready_i || reg_ready_i || unmap_ready;

	always_comb begin
		if (ram_ready_i)
			mem_rdata_o = ram_rdata_i;
		else if (reg_ready_i)
			mem_rdata_o = reg_rdata_i;
		else
			mem_rdata_o = '0;
	end

endmodule

`default_nettype wire

// File: verilog/block_ram.sv
// Single-port RAM, read returns the word as it was before a write in the same access
`timescale 1ns/1ps
`default_nettype none

module block_ram import sysctl_pkg::*; #(
	parameter int BRAM_WORDS = 1536
) (
	input  wire logic     clk,
	input  wire logic     sel_i,
	input  wire mem_req_t req_i,
	output logic          ready_o,
	output logic [31:0]   rdata_o
);

	localparam int AW = $clog2(BRAM_WORDS);

	logic [31:0]   mem [BRAM_WORDS];
	logic [AW-1:0] idx;

	assign idx = req_i.addr.ram.word[AW-1:0];

	always_ff @(posedge clk) begin
		if (sel_i) begin
			rdata_o <= mem[idx];
			for (int b = 0; b < 4; b++) begin
				if (req_i.wstrb[b])
					mem[idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
			end
		end
	end

	// Select drops while ready is high, so this is a pulse
	always_ff @(posedge clk) begin
		ready_o <= sel_i;
	end

endmodule

`default_nettype wire

// File: verilog/sys_regs.sv
// Select comes from the router decode; a data write stalls while the transmitter is busy
`timescale 1ns/1ps
`default_nettype none

module sys_regs import sysctl_pkg::*; (
	input  wire logic        clk,
	input  wire logic        resetn,
	input  wire logic        sel_i,
	input  wire mem_req_t    req_i,
	output logic             ready_o,
	output logic [31:0]      rdata_o,
	output logic             tx_start_o,
	output logic [7:0]       tx_byte_o,
	input  wire logic        tx_active_i,
	input  wire logic        rx_valid_i,
	input  wire logic [7:0]  rx_byte_i,
	input  wire logic [31:0] seconds_i,
	input  wire logic        rts_i,
	output logic             cts_o,
	output logic             led_o
);

	uart_status_t status;
	logic [15:0]  offset;
	logic         is_write;
	logic         is_data;
	logic         tx_accept;
	logic         tx_stall;
	logic         data_read;
	logic         led_write;
	logic [31:0]  rd_data;

	assign offset    = req_i.addr.regs.offset;
	assign is_write  = |req_i.wstrb;
	assign is_data   = sel_i && (offset == REG_UART_DATA);
	assign tx_accept = is_data && is_write && !status.txbusy;
	assign tx_stall  = is_data && is_write && status.txbusy;
	assign data_read = is_data && !is_write;
	assign led_write = sel_i && is_write && (offset == REG_LED);

	always_comb begin
		case (offset)
			REG_UART_DATA:   rd_data = {24'h0, rx_byte_i};
			REG_UART_STATUS: rd_data = {30'h0, status};
			// LED pin is active low
			REG_LED:         rd_data = {31'h0, ~led_o};
			REG_SECONDS:     rd_data = seconds_i;
			default:         rd_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (sel_i)
			rdata_o <= rd_data;
		if (tx_accept)
			tx_byte_o <= req_i.wdata[7:0];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			ready_o    <= 1'b0;
			tx_start_o <= 1'b0;
			status     <= '0;
			cts_o      <= 1'b0;
			led_o      <= 1'b0;
		end else begin
			ready_o    <= sel_i && !tx_stall;
			tx_start_o <= tx_accept;

			// Busy until the frame is out and the far end is ready
			if (!tx_start_o && !tx_active_i && !rts_i)
				status.txbusy <= 1'b0;
			if (tx_accept)
				status.txbusy <= 1'b1;

			if (data_read) begin
				status.dr <= 1'b0;
				cts_o     <= 1'b0;
			end
			// A byte landing with the read keeps dr set
			if (rx_valid_i) begin
				status.dr <= 1'b1;
				cts_o     <= 1'b1;
			end

			if (led_write)
				led_o <= ~req_i.wdata[0];
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart.sv
// 8N1 only, no parity; CLKS_PER_BIT must be at least 4; tx_start is ignored while a frame is sent
`timescale 1ns/1ps
`default_nettype none

module uart #(
	parameter int CLKS_PER_BIT = 8
) (
	input  wire logic       clk,
	input  wire logic       resetn,
	input  wire logic       tx_start_i,
	input  wire logic [7:0] tx_byte_i,
	output logic            tx_active_o,
	input  wire logic       rx_i,
	output logic            tx_o,
	output logic            rx_valid_o,
	output logic [7:0]      rx_byte_o
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

	logic [CW-1:0] tx_cnt;
	logic [3:0]    tx_bits;
	logic [8:0]    tx_shift;
	logic          tx_load;
	logic          tx_next;

	logic [1:0]    rx_sync;
	logic          rx_s;
	logic          rx_busy;
	logic [CW-1:0] rx_cnt;
	logic [3:0]    rx_bits;
	logic [7:0]    rx_shift;
	logic          rx_sample;

	assign tx_load = !tx_active_o && tx_start_i;
	assign tx_next = tx_active_o && (tx_cnt == BIT_LAST) && (tx_bits != 4'd0);

	// Data bits then the stop bit
	always_ff @(posedge clk) begin
		if (tx_load)
			tx_shift <= {1'b1, tx_byte_i};
		else if (tx_next)
			tx_shift <= {1'b1, tx_shift[8:1]};
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_active_o <= 1'b0;
			tx_o        <= 1'b1;
			tx_cnt      <= '0;
			tx_bits     <= '0;
		end else if (tx_load) begin
			tx_active_o <= 1'b1;
			tx_o        <= 1'b0;
			tx_cnt      <= '0;
			tx_bits     <= 4'd9;
		end else if (tx_active_o) begin
			if (tx_cnt != BIT_LAST) begin
				tx_cnt <= tx_cnt + 1'b1;
			end else begin
				tx_cnt <= '0;
				if (tx_bits == 4'd0) begin
					tx_active_o <= 1'b0;
				end else begin
					tx_o    <= tx_shift[0];
					tx_bits <= tx_bits - 1'b1;
				end
			end
		end
	end

	assign rx_s      = rx_sync[1];
	assign rx_sample = rx_busy && (rx_cnt == '0);

	// Sample 0 is the start bit, 1 to 8 data, 9 stop
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rx_sync    <= 2'b11;
			rx_busy    <= 1'b0;
			rx_cnt     <= '0;
			rx_bits    <= '0;
			rx_valid_o <= 1'b0;
		end else begin
			rx_sync    <= {rx_sync[0], rx_i};
			rx_valid_o <= 1'b0;
			if (!rx_busy) begin
				if (!rx_s) begin
					rx_busy <= 1'b1;
					rx_cnt  <= HALF_LAST;
					rx_bits <= '0;
				end
			end else if (!rx_sample) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				rx_cnt  <= BIT_LAST;
				rx_bits <= rx_bits + 1'b1;
				// False start on a glitch
				if (rx_bits == 4'd0 && rx_s)
					rx_busy <= 1'b0;
				else if (rx_bits == 4'd9) begin
					rx_busy    <= 1'b0;
					rx_valid_o <= rx_s;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rx_sample && rx_bits != 4'd0 && rx_bits != 4'd9)
			rx_shift <= {rx_s, rx_shift[7:1]};
		if (rx_sample && rx_bits == 4'd9 && rx_s)
			rx_byte_o <= rx_shift;
	end

endmodule

`default_nettype wire

// File: verilog/rtc_seconds.sv
// Seconds count wraps at 32 bits; TICKS_PER_SEC must be at least 2
`timescale 1ns/1ps
`default_nettype none

module rtc_seconds #(
	parameter int TICKS_PER_SEC = 100
) (
	input  wire logic   clk,
	input  wire logic   resetn,
	output logic [31:0] seconds_o
);

	localparam int PW = $clog2(TICKS_PER_SEC);
	localparam logic [PW-1:0] PRESC_LAST = PW'(TICKS_PER_SEC - 1);

	logic [PW-1:0] presc;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			presc     <= '0;
			seconds_o <= '0;
		end else if (presc == PRESC_LAST) begin
			presc     <= '0;
			seconds_o <= seconds_o + 1'b1;
		end else begin
			presc <= presc + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sysctl_top.sv
// One bus request at a time; BRAM_WORDS up to 16384, CLKS_PER_BIT at least 4, TICKS_PER_SEC at least 2
`timescale 1ns/1ps
`default_nettype none

module sysctl_top import sysctl_pkg::*; #(
	parameter int BRAM_WORDS    = 1536,
	parameter int CLKS_PER_BIT  = 8,
	parameter int TICKS_PER_SEC = 100
) (
	input  wire logic        clk,
	input  wire logic        resetn,
	input  wire logic        mem_valid_i,
	input  wire mem_req_t    mem_req_i,
	output logic             mem_ready_o,
	output logic [31:0]      mem_rdata_o,
	input  wire logic        uart_rx_i,
	output logic             uart_tx_o,
	input  wire logic        rts_i,
	output logic             cts_o,
	output logic             led_o
);

	logic        ram_sel;
	logic        reg_sel;
	mem_req_t    req;
	logic        ram_ready;
	logic [31:0] ram_rdata;
	logic        reg_ready;
	logic [31:0] reg_rdata;
	logic        tx_start;
	logic [7:0]  tx_byte;
	logic        tx_active;
	logic        rx_valid;
	logic [7:0]  rx_byte;
	logic [31:0] seconds;

	mem_router #(.BRAM_WORDS(BRAM_WORDS)) i_mem_router (
		.clk(clk), .resetn(resetn),
		.mem_valid_i(mem_valid_i), .mem_req_i(mem_req_i),
		.mem_ready_o(mem_ready_o), .mem_rdata_o(mem_rdata_o),
		.ram_sel_o(ram_sel), .reg_sel_o(reg_sel), .req_o(req),
		.ram_ready_i(ram_ready), .ram_rdata_i(ram_rdata),
		.reg_ready_i(reg_ready), .reg_rdata_i(reg_rdata)
	);

	block_ram #(.BRAM_WORDS(BRAM_WORDS)) i_block_ram (
		.clk(clk), .sel_i(ram_sel), .req_i(req),
		.ready_o(ram_ready), .rdata_o(ram_rdata)
	);

	sys_regs i_sys_regs (
		.clk(clk), .resetn(resetn), .sel_i(reg_sel), .req_i(req),
		.ready_o(reg_ready), .rdata_o(reg_rdata),
		.tx_start_o(tx_start), .tx_byte_o(tx_byte), .tx_active_i(tx_active),
		.rx_valid_i(rx_valid), .rx_byte_i(rx_byte), .seconds_i(seconds),
		.rts_i(rts_i), .cts_o(cts_o), .led_o(led_o)
	);

	uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart (
		.clk(clk), .resetn(resetn),
		.tx_start_i(tx_start), .tx_byte_i(tx_byte), .tx_active_o(tx_active),
		.rx_i(uart_rx_i), .tx_o(uart_tx_o),
		.rx_valid_o(rx_valid), .rx_byte_o(rx_byte)
	);

	rtc_seconds #(.TICKS_PER_SEC(TICKS_PER_SEC)) i_rtc_seconds (
		.clk(clk), .resetn(resetn), .seconds_o(seconds)
	);

endmodule

`default_nettype wire

// File: verif/sysctl_properties.sv
// Bound into mem_router and sys_regs; failures are counted in fails for the testbench to collect
`timescale 1ns/1ps
`default_nettype none

module sysctl_properties (
	input wire logic clk,
	input wire logic resetn,
	input wire logic ready_i,
	input wire logic sel_i,
	input wire logic cts_i,
	input wire logic rx_valid_i
);

	int fails = 0;

	ready_is_pulse: assert property (@(posedge clk) disable iff (!resetn) ready_i |=> !ready_i)
		else begin
			$error("ready held high for two cycles");
			fails++;
		end

	no_sel_in_reset: assert property (@(posedge clk) !resetn |-> !sel_i)
		else begin
			$error("select active during reset");
			fails++;
		end

	// CTS only follows a received byte
	cts_after_rx: assert property (@(posedge clk) disable iff (!resetn)
		$rose(cts_i) |-> $past(rx_valid_i))
		else begin
			$error("cts rose without a receive");
			fails++;
		end

endmodule

bind mem_router sysctl_properties i_router_props (
	.clk(clk), .resetn(resetn), .ready_i(mem_ready_o),
	.sel_i(ram_sel_o | reg_sel_o), .cts_i(1'b0), .rx_valid_i(1'b0)
);

bind sys_regs sysctl_properties i_regs_props (
	.clk(clk), .resetn(resetn), .ready_i(ready_o),
	.sel_i(sel_i), .cts_i(cts_o), .rx_valid_i(rx_valid_i)
);

`default_nettype wire

// File: verif/tb_sysctl.sv
// Local parameters must match the DUT build; only RAM words written earlier in the run are read back
`timescale 1ns/1ps
`default_nettype none

module tb_sysctl import sysctl_pkg::*; ();

	localparam int BRAM_WORDS    = 1536;
	localparam int CLKS_PER_BIT  = 8;
	localparam int TICKS_PER_SEC = 100;
	localparam int N_RAM   = 64;
	localparam int N_TX    = 6;
	localparam int N_RX    = 4;
	localparam int FRAME   = 10 * CLKS_PER_BIT;
	localparam int TIMEOUT = 4 * (6 * (2 * N_RAM + 24) + (N_TX + N_RX + 4) * (FRAME + 16) + 3 * 400);

	logic        clk;
	logic        resetn;
	logic        mem_valid;
	mem_req_t    mem_req;
	logic        mem_ready;
	logic [31:0] mem_rdata;
	logic        uart_rx;
	logic        uart_tx;
	logic        rts;
	logic        cts;
	logic        led;

	integer      seed = 32'ha05bedcf;
	int          errors = 0;
	int          checks = 0;
	int          cycle_count = 0;
	int          ready_cycle;
	logic [31:0] ram_model [BRAM_WORDS];
	bit          ram_known [BRAM_WORDS];
	int          known_list [$];
	logic [7:0]  tx_expect [$];
	logic [7:0]  tx_seen [$];

	sysctl_top #(
		.BRAM_WORDS(BRAM_WORDS), .CLKS_PER_BIT(CLKS_PER_BIT), .TICKS_PER_SEC(TICKS_PER_SEC)
	) i_sysctl_top (
		.clk(clk), .resetn(resetn), .mem_valid_i(mem_valid), .mem_req_i(mem_req),
		.mem_ready_o(mem_ready), .mem_rdata_o(mem_rdata), .uart_rx_i(uart_rx),
		.uart_tx_o(uart_tx), .rts_i(rts), .cts_o(cts), .led_o(led)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input uart_status_t exp, input uart_status_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s expected txbusy=%b dr=%b actual txbusy=%b dr=%b",
				name, exp.txbusy, exp.dr, act.txbusy, act.dr);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	function automatic logic [31:0] reg_addr(input logic [15:0] offset);
		return {SYSREG_REGION, 12'h0, offset};
	endfunction

	// Called at a falling edge; returns one falling edge after valid drops
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata, output int cycles);
		mem_req.addr  = addr;
		mem_req.wdata = wdata;
		mem_req.wstrb = wstrb;
		mem_valid     = 1'b1;
		cycles        = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!mem_ready);
		rdata       = mem_rdata;
		ready_cycle = cycle_count;
		mem_valid   = 1'b0;
		@(negedge clk);
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output int cycles);
		logic [31:0] ignored;
		bus_access(addr, wdata, wstrb, ignored, cycles);
	endtask

	task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata, output int cycles);
		bus_access(addr, 32'h0, 4'h0, rdata, cycles);
	endtask

	task automatic send_serial(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
	endtask

	task automatic wait_tx_frames(input int count);
		while (tx_seen.size() < count)
			@(negedge clk);
	endtask

	// Mid-bit sampling of transmitted frames
	initial begin : tx_monitor
		logic [7:0] data;
		forever begin
			@(negedge uart_tx);
			repeat (CLKS_PER_BIT / 2) @(negedge clk);
			if (uart_tx !== 1'b0) begin
				errors++;
				$display("Transmit start bit did not hold low until mid-bit");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				data[i] = uart_tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (uart_tx !== 1'b1) begin
				errors++;
				$display("Transmit frame for byte %h has no stop bit", data);
			end
			tx_seen.push_back(data);
		end
	end

	initial begin : stimulus
		logic [31:0] rdata;
		logic [31:0] wdata;
		logic [31:0] sec0;
		logic [3:0]  strb;
		logic [7:0]  tx_val;
		int          cycles;
		int          idx;
		int          start_cycle;
		int          lo;
		int          assert_fails;
		bit          write_done;
		bit          stalled;

		// A request held through reset gets no select and no ready
		resetn    = 1'b0;
		mem_valid = 1'b1;
		mem_req   = '0;
		uart_rx   = 1'b1;
		rts       = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		check_word("ready during reset", 0, {31'h0, mem_ready});
		mem_valid = 1'b0;
		resetn    = 1'b1;
		@(negedge clk);

		// RAM with byte strobes, first write of a word is a full word
		for (int i = 0; i < N_RAM; i++) begin
			idx   = int'($unsigned($random(seed)) % BRAM_WORDS);
			wdata = $random(seed);
			strb  = ram_known[idx] ? 4'($random(seed)) : 4'hf;
			if (strb == 4'h0)
				strb = 4'h1;
			bus_write(32'(idx * 4), wdata, strb, cycles);
			check_word("ram write ready", 1, cycles);
			for (int b = 0; b < 4; b++) begin
				if (strb[b])
					ram_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
			end
			if (!ram_known[idx])
				known_list.push_back(idx);
			ram_known[idx] = 1'b1;
		end
		for (int i = 0; i < N_RAM; i++) begin
			idx = known_list[$unsigned($random(seed)) % known_list.size()];
			bus_read(32'(idx * 4), rdata, cycles);
			check_word("ram read data", ram_model[idx], rdata);
			check_word("ram read ready", 1, cycles);
		end

		// Unmapped space and unknown offsets
		idx = known_list[0];
		bus_read(32'h0000_8000, rdata, cycles);
		check_word("unmapped read", 0, rdata);
		check_word("unmapped ready", 1, cycles);
		bus_read(reg_addr(16'h0008), rdata, cycles);
		check_word("unknown offset read", 0, rdata);
		check_word("unknown offset ready", 1, cycles);
		bus_write(32'h0001_0000 | 32'(idx * 4), $random(seed), 4'hf, cycles);
		check_word("unmapped write ready", 1, cycles);
		bus_write(reg_addr(16'h2000), 32'h0, 4'hf, cycles);
		bus_read(32'(idx * 4), rdata, cycles);
		check_word("ram after unmapped write", ram_model[idx], rdata);
		bus_read(reg_addr(REG_LED), rdata, cycles);
		check_word("led after reset", 1, rdata);

		for (int v = 1; v >= 0; v--) begin
			bus_write(reg_addr(REG_LED), 32'(v), 4'hf, cycles);
			check_word("led pin", 32'(1 - v), {31'h0, led});
			bus_read(reg_addr(REG_LED), rdata, cycles);
			check_word("led read", 32'(v), rdata);
		end

		// Transmit, then back-pressure with rts_i high
		for (int i = 0; i < N_TX; i++) begin
			tx_val = 8'($random(seed));
			tx_expect.push_back(tx_val);
			bus_write(reg_addr(REG_UART_DATA), {24'h0, tx_val}, 4'h1, cycles);
		end
		wait_tx_frames(N_TX);
		repeat (CLKS_PER_BIT) @(negedge clk);
		rts    = 1'b1;
		tx_val = 8'($random(seed));
		tx_expect.push_back(tx_val);
		bus_write(reg_addr(REG_UART_DATA), {24'h0, tx_val}, 4'h1, cycles);
		check_word("uart write ready", 1, cycles);
		// Frame is out, only rts_i keeps txbusy set
		wait_tx_frames(N_TX + 1);
		repeat (2 * CLKS_PER_BIT) @(negedge clk);
		bus_read(reg_addr(REG_UART_STATUS), rdata, cycles);
		check_status("status under rts", '{txbusy: 1'b1, dr: 1'b0}, uart_status_t'(rdata[1:0]));
		tx_val = 8'($random(seed));
		tx_expect.push_back(tx_val);
		write_done = 1'b0;
		fork
			begin
				bus_write(reg_addr(REG_UART_DATA), {24'h0, tx_val}, 4'h1, cycles);
				write_done = 1'b1;
			end
			begin
				repeat (2 * FRAME) @(negedge clk);
				stalled = !write_done;
				rts     = 1'b0;
			end
		join
		checks++;
		if (!stalled) begin
			errors++;
			$display("Data write completed while rts_i was held high");
		end
		wait_tx_frames(N_TX + 2);
		for (int i = 0; i < N_TX + 2; i++)
			check_byte("uart tx byte", tx_expect[i], tx_seen[i]);
		repeat (2 * CLKS_PER_BIT) @(negedge clk);

		for (int i = 0; i < N_RX; i++) begin
			tx_val = 8'($random(seed));
			send_serial(tx_val);
			repeat (2) @(negedge clk);
			check_word("cts after receive", 1, {31'h0, cts});
			bus_read(reg_addr(REG_UART_STATUS), rdata, cycles);
			check_status("status after receive", '{txbusy: 1'b0, dr: 1'b1},
				uart_status_t'(rdata[1:0]));
			bus_read(reg_addr(REG_UART_DATA), rdata, cycles);
			check_byte("uart rx byte", tx_val, rdata[7:0]);
			bus_read(reg_addr(REG_UART_STATUS), rdata, cycles);
			check_status("status after data read", '0, uart_status_t'(rdata[1:0]));
			check_word("cts after data read", 0, {31'h0, cts});
		end

		// Seconds delta against the elapsed sampling edges
		for (int i = 0; i < 3; i++) begin
			bus_read(reg_addr(REG_SECONDS), sec0, cycles);
			start_cycle = ready_cycle;
			repeat (50 + int'($unsigned($random(seed)) % 300)) @(negedge clk);
			bus_read(reg_addr(REG_SECONDS), rdata, cycles);
			lo = (ready_cycle - start_cycle) / TICKS_PER_SEC;
			if (rdata < sec0) begin
				errors++;
				$display("Seconds count went down from %0d to %0d", sec0, rdata);
			end
			checks++;
			if (rdata - sec0 != 32'(lo) && rdata - sec0 != 32'(lo + 1)) begin
				errors++;
				$display("FAIL seconds delta expected %0d or %0d actual %0d",
					lo, lo + 1, rdata - sec0);
			end
		end

		assert_fails = i_sysctl_top.i_mem_router.i_router_props.fails
			+ i_sysctl_top.i_sys_regs.i_regs_props.fails;
		$display("Checks %0d, check errors %0d, assertion failures %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
verilog/sysctl_pkg.sv
verilog/mem_router.sv
verilog/block_ram.sv
verilog/sys_regs.sv
verilog/uart.sv
verilog/rtc_seconds.sv
verilog/sysctl_top.sv
verif/sysctl_properties.sv
verif/tb_sysctl.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_sysctl -f files.f -o sim_tb_sysctl

out=$(./obj_dir/sim_tb_sysctl +verilator+error+limit+100)
echo "$out"

echo "$out" | grep -q '\*\*\* TEST PASSED \*\*\*'
echo "Simulation passed"
